/* hdl/dc_pkg.sv */
// Shared geometry, field types and transaction structs for the data cache.
// Every cache module takes what it needs from here by a wildcard import.
package dc_pkg;

  // ====================================================================
  // Cache geometry
  // ====================================================================

  // Four ways of 128 sets, each line holding four 32-bit words
  localparam int NUM_WAYS       = 4;
  localparam int NUM_SETS       = 128;
  localparam int WORDS_PER_LINE = 4;

  // Address field widths for a 32-bit physical address
  localparam int NDX_W  = $clog2(NUM_SETS);
  localparam int WSEL_W = $clog2(WORDS_PER_LINE);
  localparam int BOFF_W = 2;
  localparam int TAG_W  = 32 - NDX_W - WSEL_W - BOFF_W;

  // ====================================================================
  // Field types
  // ====================================================================

  typedef logic [TAG_W-1:0]             dc_tag_t;
  typedef logic [NDX_W-1:0]             dc_ndx_t;
  typedef logic [$clog2(NUM_WAYS)-1:0]  dc_way_t;
  typedef logic [31:0]                  dc_word_t;

  // Word 0 of a line sits in the low 32 bits
  typedef dc_word_t [WORDS_PER_LINE-1:0] dc_line_t;

  // ====================================================================
  // Transaction structs
  // ====================================================================

  // Physical address, most significant field first
  typedef struct packed {
    dc_tag_t           tag;
    dc_ndx_t           ndx;
    logic [WSEL_W-1:0] wsel;
    logic [BOFF_W-1:0] boff;
  } dc_addr_t;

  // A fill carries the line address and the full line contents
  typedef struct packed {
    dc_addr_t addr;
    dc_line_t line;
  } dc_fill_t;

  // Lookup result returned by the output stage
  typedef struct packed {
    logic     hit;
    dc_way_t  way;
    dc_word_t word;
    dc_addr_t addr;
  } dc_rsp_t;

endpackage

/* hdl/dc_req_stage.sv */
// Input register of the cache. Captures lookup, fill and flush strobes
// and presents the registered address fields to the set RAM read port.
module dc_req_stage #(
  parameter int AWID = 32
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               req,
  input  dc_pkg::dc_addr_t   req_addr,
  input  logic               fill,
  input  dc_pkg::dc_fill_t   fill_req,
  input  logic               flush,
  output logic               lk_valid,
  output dc_pkg::dc_addr_t   lk_addr,
  output logic               fill_q,
  output dc_pkg::dc_fill_t   fill_data_q,
  output logic               flush_q
);
  import dc_pkg::*;

  // The address struct has to cover the whole physical address
  if (AWID != $bits(dc_addr_t)) begin : g_awid_check
    $error("Address width does not match the address struct");
  end

  // Strobes are control state and come out of reset low
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lk_valid <= 1'b0;
      fill_q   <= 1'b0;
      flush_q  <= 1'b0;
    end
    else
    begin
      lk_valid <= req;
      fill_q   <= fill;
      flush_q  <= flush;
    end
  end

  // The read port follows lk_addr.ndx, so a pending fill steers it to the fill set
  // Lookups and fills never share a cycle, so nothing is lost by the choice
  always_ff @(posedge clk)
  begin
    lk_addr     <= fill ? fill_req.addr : req_addr;
    fill_data_q <= fill_req;
  end

  // The three request kinds are mutually exclusive on the input side
  a_one_strobe : assert property (@(posedge clk) disable iff (rst)
    $onehot0({req, fill, flush}));

endmodule

/* hdl/dc_set_ram.sv */
// Four-way set RAM with a registered read of a whole set and one write way.
// Instanced once for the tags and once for the line data.
module dc_set_ram #(
  parameter type entry_t = dc_pkg::dc_tag_t
) (
  input  logic             clk,
  input  dc_pkg::dc_ndx_t  rd_ndx,
  output entry_t           rd_data [dc_pkg::NUM_WAYS],
  input  logic             wr_en,
  input  dc_pkg::dc_way_t  wr_way,
  input  dc_pkg::dc_ndx_t  wr_ndx,
  input  entry_t           wr_data
);
  import dc_pkg::*;

  // ====================================================================
  // One memory per way
  // ====================================================================

  // Each way is a separate array so it maps onto its own block RAM
  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    entry_t mem [NUM_SETS];

    // Only the way picked by the victim pointer takes the write
    always_ff @(posedge clk)
    begin
      if (wr_en && (wr_way == dc_way_t'(w)))
      begin
        mem[wr_ndx] <= wr_data;
      end
    end

    // Synchronous read of the addressed set in every way at once
    // A read of the set being written returns the old entry
    always_ff @(posedge clk)
    begin
      rd_data[w] <= mem[rd_ndx];
    end
  end

endmodule

/* hdl/dc_line_state.sv */
// Valid bits and round-robin victim pointers of every set.
// Also delays the lookup one cycle so it lines up with the set RAM outputs.
module dc_line_state (
  input  logic             clk,
  input  logic             rst,
  input  logic             lk_valid,
  input  dc_pkg::dc_addr_t lk_addr,
  input  logic             fill_q,
  input  dc_pkg::dc_ndx_t  fill_ndx,
  input  logic             flush_q,
  output dc_pkg::dc_way_t  victim,
  output logic [dc_pkg::NUM_WAYS-1:0] set_valid,
  output logic             lk_valid_q,
  output dc_pkg::dc_addr_t lk_addr_q
);
  import dc_pkg::*;

  // One valid bit per way and one victim pointer per set
  logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
  dc_way_t             ptr_q   [NUM_SETS];

  // The victim is simply the pointer of the set being filled
  assign victim = ptr_q[fill_ndx];

  // ====================================================================
  // Line state update
  // ====================================================================

  // Flush empties the whole cache in one cycle
  always_ff @(posedge clk)
  begin
    if (rst || flush_q)
    begin
      for (int s = 0; s < NUM_SETS; s++)
      begin
        valid_q[s] <= '0;
        ptr_q[s]   <= '0;
      end
    end
    else if (fill_q)
    begin
      // Mark the new line and step the pointer, wrapping after the last way
      valid_q[fill_ndx][victim] <= 1'b1;
      ptr_q[fill_ndx]           <= victim + dc_way_t'(1);
    end
  end

  // ====================================================================
  // Lookup alignment
  // ====================================================================

  // Registered in the same edge as the RAM read, so all three line up
  always_ff @(posedge clk)
  begin
    set_valid <= valid_q[lk_addr.ndx];
    lk_addr_q <= lk_addr;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      lk_valid_q <= 1'b0;
    else
      lk_valid_q <= lk_valid;
  end

  // A fill and a flush in the same cycle would leave the set state undefined
  a_fill_flush : assert property (@(posedge clk) disable iff (rst)
    !(fill_q && flush_q));

endmodule

/* hdl/dc_hit_detect.sv */
// Four-way tag compare. Produces the hit vector, the hit flag and the way
// reported for the lookup, which falls back to the last hitting way on a miss.
module dc_hit_detect #(
  parameter int AWID = 32
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             lk_valid_q,
  input  dc_pkg::dc_addr_t lk_addr_q,
  input  dc_pkg::dc_tag_t  tags [dc_pkg::NUM_WAYS],
  input  logic [dc_pkg::NUM_WAYS-1:0] set_valid,
  output logic [dc_pkg::NUM_WAYS-1:0] hits,
  output logic             hit,
  output dc_pkg::dc_way_t  way
);
  import dc_pkg::*;

  // Tag bits are whatever remains above index, word select and byte offset
  localparam int LK_TAG_W = AWID - NDX_W - WSEL_W - BOFF_W;

  logic [LK_TAG_W-1:0] lk_tag;
  dc_way_t             last_way_q;

  assign lk_tag = lk_addr_q[AWID-1 -: LK_TAG_W];

  // A way hits only when its line is valid and the tag matches
  always_comb
  begin
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      hits[w] = set_valid[w] && (tags[w] == lk_tag);
    end
  end

  assign hit = |hits;

  // Lowest numbered hitting way wins, otherwise keep the remembered way
  // The scan runs downward so the lowest way is assigned last
  always_comb
  begin
    way = last_way_q;
    for (int w = NUM_WAYS - 1; w >= 0; w--)
    begin
      if (hits[w])
        way = dc_way_t'(w);
    end
  end

  // Only a real lookup that hits moves the remembered way
  always_ff @(posedge clk)
  begin
    if (rst)
      last_way_q <= '0;
    else if (lk_valid_q && hit)
      last_way_q <= way;
  end

  // Fills never load an address already present, so one way at most matches
  a_single_hit : assert property (@(posedge clk) disable iff (rst)
    lk_valid_q |-> $onehot0(hits));

endmodule

/* hdl/dc_rsp_stage.sv */
// Output register of the cache. Picks the word of the reported way and
// returns it with the hit flag, the way and the lookup address.
module dc_rsp_stage (
  input  logic             clk,
  input  logic             rst,
  input  logic             lk_valid_q,
  input  dc_pkg::dc_addr_t lk_addr_q,
  input  dc_pkg::dc_line_t lines [dc_pkg::NUM_WAYS],
  input  logic             hit,
  input  dc_pkg::dc_way_t  way,
  output logic             rsp_valid,
  output dc_pkg::dc_rsp_t  rsp
);
  import dc_pkg::*;

  dc_line_t sel_line;
  dc_word_t sel_word;

  // Line of the reported way, then the word named by the word select
  assign sel_line = lines[way];

  // A miss returns a zero word whatever the reported way holds
  assign sel_word = hit ? sel_line[lk_addr_q.wsel] : '0;

  // Response payload is only meaningful while rsp_valid is high
  always_ff @(posedge clk)
  begin
    rsp.hit  <= hit;
    rsp.way  <= way;
    rsp.word <= sel_word;
    rsp.addr <= lk_addr_q;
  end

  // One valid pulse per accepted lookup
  always_ff @(posedge clk)
  begin
    if (rst)
      rsp_valid <= 1'b0;
    else
      rsp_valid <= lk_valid_q;
  end

endmodule

/* hdl/dc_top.sv */
// Top level of the four-way data cache. Connects the request register,
// the tag and data set RAMs, the line state, the hit detector and the response.
module dc_top #(
  parameter int AWID = 32
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             req,
  input  dc_pkg::dc_addr_t req_addr,
  input  logic             fill,
  input  dc_pkg::dc_fill_t fill_req,
  input  logic             flush,
  output logic             rsp_valid,
  output dc_pkg::dc_rsp_t  rsp
);
  import dc_pkg::*;

  // Request stage outputs
  logic     lk_valid;
  dc_addr_t lk_addr;
  logic     fill_q;
  dc_fill_t fill_data_q;
  logic     flush_q;

  // Set RAM and line state outputs, aligned one cycle after the request stage
  dc_tag_t             tag_rd  [NUM_WAYS];
  dc_line_t            line_rd [NUM_WAYS];
  dc_way_t             victim;
  logic [NUM_WAYS-1:0] set_valid;
  logic                lk_valid_q;
  dc_addr_t            lk_addr_q;

  // Hit detector outputs
  logic                hit;
  dc_way_t             way;

  // ====================================================================
  // Input side
  // ====================================================================

  dc_req_stage #(
    .AWID (AWID)
  ) u_req (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .req_addr    (req_addr),
    .fill        (fill),
    .fill_req    (fill_req),
    .flush       (flush),
    .lk_valid    (lk_valid),
    .lk_addr     (lk_addr),
    .fill_q      (fill_q),
    .fill_data_q (fill_data_q),
    .flush_q     (flush_q)
  );

  // ====================================================================
  // Tag and data sets, line state and hit detect
  // ====================================================================

  // Both RAMs write the victim way of the fill set
  dc_set_ram #(
    .entry_t (dc_tag_t)
  ) tag_ram (
    .clk     (clk),
    .rd_ndx  (lk_addr.ndx),
    .rd_data (tag_rd),
    .wr_en   (fill_q),
    .wr_way  (victim),
    .wr_ndx  (fill_data_q.addr.ndx),
    .wr_data (fill_data_q.addr.tag)
  );

  dc_set_ram #(
    .entry_t (dc_line_t)
  ) data_ram (
    .clk     (clk),
    .rd_ndx  (lk_addr.ndx),
    .rd_data (line_rd),
    .wr_en   (fill_q),
    .wr_way  (victim),
    .wr_ndx  (fill_data_q.addr.ndx),
    .wr_data (fill_data_q.line)
  );

  dc_line_state u_state (
    .clk        (clk),
    .rst        (rst),
    .lk_valid   (lk_valid),
    .lk_addr    (lk_addr),
    .fill_q     (fill_q),
    .fill_ndx   (fill_data_q.addr.ndx),
    .flush_q    (flush_q),
    .victim     (victim),
    .set_valid  (set_valid),
    .lk_valid_q (lk_valid_q),
    .lk_addr_q  (lk_addr_q)
  );

  dc_hit_detect #(
    .AWID (AWID)
  ) u_hit (
    .clk        (clk),
    .rst        (rst),
    .lk_valid_q (lk_valid_q),
    .lk_addr_q  (lk_addr_q),
    .tags       (tag_rd),
    .set_valid  (set_valid),
    .hits       (),
    .hit        (hit),
    .way        (way)
  );

  // ====================================================================
  // Output side
  // ====================================================================

  dc_rsp_stage u_rsp (
    .clk        (clk),
    .rst        (rst),
    .lk_valid_q (lk_valid_q),
    .lk_addr_q  (lk_addr_q),
    .lines      (line_rd),
    .hit        (hit),
    .way        (way),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp)
  );

endmodule

/* dv/dc_tb.sv */
// Testbench for the four-way data cache. Applies a table of fills, flushes and
// lookups, and checks each response against a reference model of the cache.
module dc_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import dc_pkg::*;

  localparam logic [1:0] OP_LOOKUP = 2'd0;
  localparam logic [1:0] OP_FILL   = 2'd1;
  localparam logic [1:0] OP_FLUSH  = 2'd2;

  // One table row: what to apply, and the hit and way worked out by hand
  typedef struct packed {
    logic [1:0] kind;
    dc_addr_t   addr;
    dc_line_t   line;
    logic       hit;
    dc_way_t    way;
  } op_t;

  // A response still in flight, with the cycle count at which it is due
  typedef struct packed {
    logic [31:0] due;
    logic [31:0] idx;
    logic        hit;
    dc_way_t     way;
    dc_word_t    word;
    dc_addr_t    addr;
  } exp_t;

  logic     clk = 1'b0;
  logic     rst;
  logic     req;
  dc_addr_t req_addr;
  logic     fill;
  dc_fill_t fill_req;
  logic     flush;
  logic     rsp_valid;
  dc_rsp_t  rsp;

  op_t         ops [$];
  exp_t        exp_q [$];
  logic [31:0] rng = 32'h1da7;
  int          cyc = 0;
  int          n_ops = 0;
  int          n_checks = 0;
  int          n_errors = 0;

  // Reference model of the cache contents, pointers and remembered way
  logic     m_valid [NUM_WAYS][NUM_SETS];
  dc_tag_t  m_tag   [NUM_WAYS][NUM_SETS];
  dc_line_t m_line  [NUM_WAYS][NUM_SETS];
  dc_way_t  m_ptr   [NUM_SETS];
  dc_way_t  m_last;

  dc_top #(.AWID (32)) uut (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .req_addr  (req_addr),
    .fill      (fill),
    .fill_req  (fill_req),
    .flush     (flush),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  always #20 clk = ~clk;

  // Free running cycle count; the driver reads it before the edge updates it
  always @(posedge clk)
    cyc <= cyc + 1;

  // ====================================================================
  // Stimulus helpers and reference model
  // ====================================================================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Byte offset is filled from the tag so that nonzero offsets show up
  function automatic dc_addr_t make_addr(input dc_tag_t tag, input dc_ndx_t ndx,
                                         input logic [1:0] wsel);
    dc_addr_t a;
    a.tag  = tag;
    a.ndx  = ndx;
    a.wsel = wsel;
    a.boff = tag[1:0];
    return a;
  endfunction

  task automatic add_op(input logic [1:0] kind, input dc_addr_t addr,
                        input logic hit, input dc_way_t way);
    op_t o;
    o.kind = kind;
    o.addr = addr;
    o.hit  = hit;
    o.way  = way;
    o.line = '0;
    // Fill lines come from the random stream, one word at a time
    if (kind == OP_FILL)
    begin
      for (int w = 0; w < WORDS_PER_LINE; w++)
      begin
        rng = xorshift32(rng);
        o.line[w] = rng;
      end
    end
    ops.push_back(o);
  endtask

  // The victim is the set's pointer, which then steps round the four ways
  task automatic model_fill(input dc_addr_t a, input dc_line_t line);
    dc_way_t w;
    w = m_ptr[a.ndx];
    m_valid[w][a.ndx] = 1'b1;
    m_tag[w][a.ndx]   = a.tag;
    m_line[w][a.ndx]  = line;
    m_ptr[a.ndx]      = w + 2'd1;
  endtask

  task automatic model_flush();
    for (int s = 0; s < NUM_SETS; s++)
    begin
      m_ptr[s] = '0;
      for (int w = 0; w < NUM_WAYS; w++)
        m_valid[w][s] = 1'b0;
    end
  endtask

  // Lowest hitting way wins; a miss reports the way of the last hit
  task automatic model_lookup(input dc_addr_t a, output exp_t e);
    e.hit  = 1'b0;
    e.way  = m_last;
    e.word = '0;
    e.addr = a;
    for (int w = NUM_WAYS - 1; w >= 0; w--)
    begin
      if (m_valid[w][a.ndx] && (m_tag[w][a.ndx] == a.tag))
      begin
        e.hit = 1'b1;
        e.way = dc_way_t'(w);
      end
    end
    if (e.hit)
    begin
      e.word = m_line[e.way][a.ndx][a.wsel];
      m_last = e.way;
    end
  endtask

  task automatic check_rsp(input exp_t e);
    int bad;
    bad = 0;
    n_checks++;
    if (rsp.hit !== e.hit)
    begin
      $display("Mismatch at %0t: op %0d hit %0b, expected %0b", $time, e.idx, rsp.hit, e.hit);
      bad++;
    end
    if (rsp.way !== e.way)
    begin
      $display("Mismatch at %0t: op %0d way %0d, expected %0d", $time, e.idx, rsp.way, e.way);
      bad++;
    end
    if (rsp.word !== e.word)
    begin
      $display("Mismatch at %0t: op %0d word %h, expected %h", $time, e.idx, rsp.word, e.word);
      bad++;
    end
    if (rsp.addr !== e.addr)
    begin
      $display("Mismatch at %0t: op %0d addr %h, expected %h", $time, e.idx, rsp.addr, e.addr);
      bad++;
    end
    n_errors += bad;
    $display("op %0d lookup %h hit %0b way %0d: %s", e.idx, e.addr, e.hit, e.way,
             (bad == 0) ? "pass" : "fail");
  endtask

  // ====================================================================
  // Response checker, sampled on the falling edge where outputs are stable
  // ====================================================================

  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (rsp_valid)
      begin
        if (exp_q.size() == 0 || exp_q[0].due != cyc)
        begin
          $display("Error at %0t: rsp_valid came with no lookup due in this cycle", $time);
          n_errors++;
        end
        else
          check_rsp(exp_q.pop_front());
      end
      else if (exp_q.size() != 0 && exp_q[0].due == cyc)
      begin
        $display("Error at %0t: no response for op %0d three cycles after it", $time,
                 exp_q[0].idx);
        n_errors++;
        void'(exp_q.pop_front());
      end
    end
  end

  // ====================================================================
  // Operation table and driver
  // ====================================================================

  initial
  begin
    exp_t e;
    rst      = 1'b1;
    req      = 1'b0;
    req_addr = '0;
    fill     = 1'b0;
    fill_req = '0;
    flush    = 1'b0;
    model_flush();
    m_last = '0;

    // Cold cache, every lookup misses with way 0
    add_op(OP_LOOKUP, make_addr(21'h00005, 7'd3, 2'd1), 1'b0, 2'd0);
    add_op(OP_LOOKUP, make_addr(21'h1abcd, 7'd127, 2'd3), 1'b0, 2'd0);
    // Four fills to set 10 land in ways 0 to 3
    add_op(OP_FILL, make_addr(21'h00100, 7'd10, 2'd0), 1'b0, 2'd0);
    add_op(OP_FILL, make_addr(21'h00101, 7'd10, 2'd0), 1'b0, 2'd0);
    add_op(OP_FILL, make_addr(21'h00102, 7'd10, 2'd0), 1'b0, 2'd0);
    add_op(OP_FILL, make_addr(21'h00103, 7'd10, 2'd0), 1'b0, 2'd0);
    add_op(OP_LOOKUP, make_addr(21'h00102, 7'd10, 2'd2), 1'b1, 2'd2);
    add_op(OP_LOOKUP, make_addr(21'h00100, 7'd10, 2'd1), 1'b1, 2'd0);
    add_op(OP_LOOKUP, make_addr(21'h00103, 7'd10, 2'd3), 1'b1, 2'd3);
    add_op(OP_LOOKUP, make_addr(21'h00101, 7'd10, 2'd0), 1'b1, 2'd1);
    // Misses report the way of the most recent hit
    add_op(OP_LOOKUP, make_addr(21'h00555, 7'd10, 2'd0), 1'b0, 2'd1);
    add_op(OP_LOOKUP, make_addr(21'h00103, 7'd10, 2'd1), 1'b1, 2'd3);
    add_op(OP_LOOKUP, make_addr(21'h00103, 7'd20, 2'd1), 1'b0, 2'd3);
    // Fifth fill to set 10 replaces way 0
    add_op(OP_FILL, make_addr(21'h00104, 7'd10, 2'd0), 1'b0, 2'd0);
    add_op(OP_LOOKUP, make_addr(21'h00100, 7'd10, 2'd0), 1'b0, 2'd3);
    add_op(OP_LOOKUP, make_addr(21'h00104, 7'd10, 2'd2), 1'b1, 2'd0);
    // Back to back lookups with a miss in the middle
    add_op(OP_LOOKUP, make_addr(21'h00101, 7'd10, 2'd3), 1'b1, 2'd1);
    add_op(OP_LOOKUP, make_addr(21'h00102, 7'd10, 2'd1), 1'b1, 2'd2);
    add_op(OP_LOOKUP, make_addr(21'h00777, 7'd10, 2'd2), 1'b0, 2'd2);
    add_op(OP_LOOKUP, make_addr(21'h00104, 7'd10, 2'd3), 1'b1, 2'd0);
    // Flush empties the cache and restarts every pointer at way 0
    add_op(OP_FLUSH, '0, 1'b0, 2'd0);
    add_op(OP_LOOKUP, make_addr(21'h00104, 7'd10, 2'd2), 1'b0, 2'd0);
    add_op(OP_LOOKUP, make_addr(21'h00102, 7'd10, 2'd0), 1'b0, 2'd0);
    add_op(OP_FILL, make_addr(21'h00200, 7'd50, 2'd0), 1'b0, 2'd0);
    add_op(OP_FILL, make_addr(21'h00201, 7'd10, 2'd0), 1'b0, 2'd0);
    add_op(OP_LOOKUP, make_addr(21'h00201, 7'd10, 2'd1), 1'b1, 2'd0);
    add_op(OP_LOOKUP, make_addr(21'h00200, 7'd50, 2'd2), 1'b1, 2'd0);
    n_ops = ops.size();

    repeat (16) @(posedge clk);
    rst <= 1'b0;

    // One row per cycle; the response is due four counts after the drive edge
    foreach (ops[i])
    begin
      @(posedge clk);
      req   <= (ops[i].kind == OP_LOOKUP);
      fill  <= (ops[i].kind == OP_FILL);
      flush <= (ops[i].kind == OP_FLUSH);
      req_addr      <= ops[i].addr;
      fill_req.addr <= ops[i].addr;
      fill_req.line <= ops[i].line;
      case (ops[i].kind)
        OP_FILL:  model_fill(ops[i].addr, ops[i].line);
        OP_FLUSH: model_flush();
        default:
        begin
          model_lookup(ops[i].addr, e);
          e.due = cyc + 4;
          e.idx = i;
          if (e.hit !== ops[i].hit || e.way !== ops[i].way)
          begin
            $display("Error: table row %0d disagrees with the reference model", i);
            n_errors++;
          end
          exp_q.push_back(e);
        end
      endcase
    end
    @(posedge clk);
    req   <= 1'b0;
    fill  <= 1'b0;
    flush <= 1'b0;

    // Drain the pipeline, then leave a few cycles to catch stray responses
    while (exp_q.size() != 0)
      @(posedge clk);
    repeat (4) @(posedge clk);

    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  // Watchdog sized from the table length with margin for reset and drain
  initial
  begin
    wait (n_ops > 0);
    #((n_ops + 40) * 40);
    $display("Timeout: the run did not finish in the expected time");
    $display("Errors found");
    $finish;
  end

endmodule

/* sim.f */
hdl/dc_pkg.sv
hdl/dc_req_stage.sv
hdl/dc_set_ram.sv
hdl/dc_line_state.sv
hdl/dc_hit_detect.sv
hdl/dc_rsp_stage.sv
hdl/dc_top.sv
dv/dc_tb.sv
